//--- design/packer_pkg.sv
package packer_pkg;

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Element format and vector geometry
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	localparam int LANES = 16; // Elements per vector.
	localparam int ELEM_INT_BITS = 8;
	localparam int ELEM_FRAC_BITS = 12;
	localparam int ELEM_BITS = ELEM_INT_BITS + ELEM_FRAC_BITS;
	localparam int LANE_IDX_BITS = $clog2(LANES);

	// Signed fixed point in 8.12 format.
	typedef logic signed [ELEM_BITS-1:0] elem_t;

	// Scan index and write pointer.
	typedef logic [LANE_IDX_BITS-1:0] lane_idx_t;

	// Lane 0 sits in the low bits.
	typedef elem_t [LANES-1:0] vec_t;

	localparam elem_t ELEM_ZERO = '0;
	localparam lane_idx_t LAST_LANE = lane_idx_t'(LANES - 1);

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Operand bundle and control states
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	typedef struct packed {
		vec_t act; // Activations.
		vec_t wgt; // Weights.
	} operand_pair_t;

	typedef enum logic [1:0] {
		ST_IDLE = 2'b00, // Waiting for input_ready.
		ST_SCAN = 2'b01, // One lane per cycle.
		ST_HOLD = 2'b10  // Result held until taken.
	} pack_state_t;

endpackage

//--- design/pack_ctrl.sv
`timescale 1ns/10ps

module pack_ctrl (
	input  logic                   clk,
	input  logic                   reset,
	input  logic                   i_input_ready,
	input  logic                   i_output_taken,
	output logic                   o_capture,
	output logic                   o_scan,
	output logic                   o_last,
	output logic                   o_release,
	output packer_pkg::lane_idx_t  o_scan_idx,
	output logic                   o_input_taken,
	output packer_pkg::pack_state_t o_state
);

	packer_pkg::pack_state_t state;
	packer_pkg::pack_state_t state_next;
	packer_pkg::lane_idx_t   scan_idx;
	logic                    input_taken;

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Strobes to the compactors
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	always_comb begin
		o_capture = (state == packer_pkg::ST_IDLE) && i_input_ready;
		o_scan    = (state == packer_pkg::ST_SCAN);
		o_last    = o_scan && (scan_idx == packer_pkg::LAST_LANE);
		o_release = (state == packer_pkg::ST_HOLD) && i_output_taken;
	end

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// State machine
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	always_comb begin
		state_next = state;
		case (state)
			packer_pkg::ST_IDLE: begin
				if (o_capture) begin
					state_next = packer_pkg::ST_SCAN;
				end
			end
			packer_pkg::ST_SCAN: begin
				if (o_last) begin
					state_next = packer_pkg::ST_HOLD; // Result loads on this edge.
				end
			end
			packer_pkg::ST_HOLD: begin
				if (o_release) begin
					state_next = packer_pkg::ST_IDLE;
				end
			end
			default: begin
				state_next = packer_pkg::ST_IDLE;
			end
		endcase
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			state <= packer_pkg::ST_IDLE;
		end else begin
			state <= state_next;
		end
	end

	// Scan index steps from 0 to LANES-1 once per scan cycle.
	always_ff @(posedge clk) begin
		if (reset || o_capture || o_last) begin
			scan_idx <= '0;
		end else if (o_scan) begin
			scan_idx <= scan_idx + 1'b1;
		end
	end

	always_ff @(posedge clk) begin
		if (reset || o_release) begin
			input_taken <= 1'b0;
		end else if (o_capture) begin
			input_taken <= 1'b1; // Stays up through scan and hold.
		end
	end

	assign o_scan_idx    = scan_idx;
	assign o_input_taken = input_taken;
	assign o_state       = state;

endmodule

//--- design/lane_compactor.sv
`timescale 1ns/10ps

module lane_compactor (
	input  logic                  clk,
	input  logic                  reset,
	input  logic                  i_capture,
	input  logic                  i_scan,
	input  logic                  i_last,
	input  logic                  i_release,
	input  packer_pkg::lane_idx_t i_scan_idx,
	input  packer_pkg::vec_t      i_vec,
	output packer_pkg::vec_t      o_vec
);

	packer_pkg::vec_t      src_vec;   // Captured source.
	packer_pkg::vec_t      work_vec;  // Packed so far.
	packer_pkg::vec_t      work_next;
	packer_pkg::vec_t      result_vec;
	packer_pkg::lane_idx_t write_ptr; // Next free lane.
	packer_pkg::lane_idx_t write_ptr_next;
	packer_pkg::elem_t     scan_elem;
	logic                  elem_nonzero;

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Zero test on the element under the scan index
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	always_comb begin
		scan_elem    = src_vec[i_scan_idx];
		elem_nonzero = (scan_elem != packer_pkg::ELEM_ZERO);
	end

	// Nonzero elements land in order at the write pointer.
	always_comb begin
		work_next      = work_vec;
		write_ptr_next = write_ptr;
		if (elem_nonzero) begin
			work_next[write_ptr] = scan_elem;
			write_ptr_next       = write_ptr + 1'b1;
		end
	end

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Source, working vector and pointer
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	always_ff @(posedge clk) begin
		if (reset || i_release) begin
			src_vec   <= '0;
			work_vec  <= '0;
			write_ptr <= '0;
		end else if (i_capture) begin
			src_vec   <= i_vec;
			work_vec  <= '0; // Unfilled lanes stay zero.
			write_ptr <= '0;
		end else if (i_scan) begin
			work_vec  <= work_next;
			write_ptr <= write_ptr_next;
		end
	end

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Result register
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	// Includes the element seen on the last scan cycle.
	always_ff @(posedge clk) begin
		if (reset || i_release) begin
			result_vec <= '0;
		end else if (i_scan && i_last) begin
			result_vec <= work_next;
		end
	end

	assign o_vec = result_vec;

endmodule

//--- design/zero_skip_packer.sv
`timescale 1ns/10ps

module zero_skip_packer (
	input  logic                      clk,
	input  logic                      reset,
	input  packer_pkg::operand_pair_t i_operands,
	input  logic                      i_input_ready,
	input  logic                      i_output_taken,
	output packer_pkg::operand_pair_t o_operands,
	output logic                      o_input_taken,
	output packer_pkg::pack_state_t   o_state
);

	logic                  capture_pulse;
	logic                  scan_active;
	logic                  scan_last;
	logic                  release_pulse;
	packer_pkg::lane_idx_t scan_idx;

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Control
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	pack_ctrl u_ctrl (
		.clk            (clk),
		.reset          (reset),
		.i_input_ready  (i_input_ready),
		.i_output_taken (i_output_taken),
		.o_capture      (capture_pulse),
		.o_scan         (scan_active),
		.o_last         (scan_last),
		.o_release      (release_pulse),
		.o_scan_idx     (scan_idx),
		.o_input_taken  (o_input_taken),
		.o_state        (o_state)
	);

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// One compactor per operand on shared strobes
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	lane_compactor u_act_compactor (
		.clk        (clk),
		.reset      (reset),
		.i_capture  (capture_pulse),
		.i_scan     (scan_active),
		.i_last     (scan_last),
		.i_release  (release_pulse),
		.i_scan_idx (scan_idx),
		.i_vec      (i_operands.act),
		.o_vec      (o_operands.act)
	);

	lane_compactor u_wgt_compactor (
		.clk        (clk),
		.reset      (reset),
		.i_capture  (capture_pulse),
		.i_scan     (scan_active),
		.i_last     (scan_last),
		.i_release  (release_pulse),
		.i_scan_idx (scan_idx),
		.i_vec      (i_operands.wgt),
		.o_vec      (o_operands.wgt)
	);

endmodule

//--- verif/zero_skip_packer_props.sv
`timescale 1ns/10ps

module zero_skip_packer_props (
	input logic                      clk,
	input logic                      reset,
	input logic                      i_input_ready,
	input logic                      i_output_taken,
	input packer_pkg::operand_pair_t o_operands,
	input logic                      o_input_taken,
	input packer_pkg::pack_state_t   o_state
);

	logic capture_seen;

	assign capture_seen = (o_state == packer_pkg::ST_IDLE) && i_input_ready;

	// Sampled state lags the edge by one.
	a_capture_to_hold: assert property (@(posedge clk) disable iff (reset)
		$past(capture_seen, packer_pkg::LANES + 1) |-> o_state == packer_pkg::ST_HOLD)
		else $error("Result not held LANES cycles after capture");

	a_idle_not_taken: assert property (@(posedge clk) disable iff (reset)
		o_state == packer_pkg::ST_IDLE |-> !o_input_taken)
		else $error("input_taken set while idle");

	a_no_idle_to_hold: assert property (@(posedge clk) disable iff (reset)
		o_state == packer_pkg::ST_IDLE |=> o_state != packer_pkg::ST_HOLD)
		else $error("Idle went straight to hold");

	a_hold_stable: assert property (@(posedge clk) disable iff (reset)
		(o_state == packer_pkg::ST_HOLD && !i_output_taken) |=> $stable(o_operands))
		else $error("Result changed while held");

endmodule

bind zero_skip_packer zero_skip_packer_props u_props (
	.clk            (clk),
	.reset          (reset),
	.i_input_ready  (i_input_ready),
	.i_output_taken (i_output_taken),
	.o_operands     (o_operands),
	.o_input_taken  (o_input_taken),
	.o_state        (o_state)
);

//--- verif/tb_zero_skip_packer.sv
`timescale 1ns/10ps

module tb_zero_skip_packer;

	localparam int TXN_CYCLES = 20; // Capture, scan, short hold, release.
	localparam int NUM_TXN    = 10;
	localparam int MAX_CYCLES = 2 * TXN_CYCLES * NUM_TXN;

	logic                      clk;
	logic                      reset;
	packer_pkg::operand_pair_t in_ops;
	logic                      input_ready;
	logic                      output_taken;
	packer_pkg::operand_pair_t out_ops;
	logic                      input_taken;
	packer_pkg::pack_state_t   state;
	int                        cycle_count = 0;

	zero_skip_packer u_zero_skip_packer (
		.clk            (clk),
		.reset          (reset),
		.i_operands     (in_ops),
		.i_input_ready  (input_ready),
		.i_output_taken (output_taken),
		.o_operands     (out_ops),
		.o_input_taken  (input_taken),
		.o_state        (state)
	);

	initial begin
		clk = 1'b0;
		forever #4 clk = ~clk;
	end

	always @(posedge clk) begin
		cycle_count <= cycle_count + 1;
		if (cycle_count >= MAX_CYCLES) begin
			$display("Timeout: the tests did not finish within %0d cycles", MAX_CYCLES);
			$display("Simulation failed");
			$fatal(1, "Cycle limit reached");
		end
	end

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Reference model and stimulus helpers
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	// Nonzero elements in order, then zeros.
	function automatic packer_pkg::vec_t pack_model(input packer_pkg::vec_t v);
		packer_pkg::vec_t r;
		int               n;
		r = '0;
		n = 0;
		for (int i = 0; i < packer_pkg::LANES; i++) begin
			if (v[i] != '0) begin
				r[n] = v[i];
				n++;
			end
		end
		return r;
	endfunction

	function automatic packer_pkg::vec_t random_vec();
		packer_pkg::vec_t v;
		for (int i = 0; i < packer_pkg::LANES; i++) begin
			if ($urandom_range(1, 0) == 0) begin
				v[i] = '0; // Half the lanes are zero.
			end else begin
				v[i] = packer_pkg::elem_t'($urandom);
			end
		end
		return v;
	endfunction

	task automatic next_cycle();
		@(posedge clk);
		#1;
	endtask

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Compare tasks
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	task automatic check_vec(input string test, input string what,
			input packer_pkg::vec_t expected, input packer_pkg::vec_t actual);
		if (actual !== expected) begin
			$display("[FAIL] %s %s: expected %h, actual %h", test, what, expected, actual);
			$display("Simulation failed");
			$fatal(1, "Vector mismatch");
		end
	endtask

	task automatic check_state(input string test, input packer_pkg::pack_state_t expected,
			input packer_pkg::pack_state_t actual);
		if (actual !== expected) begin
			$display("[FAIL] %s state: expected %s, actual %s", test, expected.name(),
				actual.name());
			$display("Simulation failed");
			$fatal(1, "State mismatch");
		end
	endtask

	task automatic check_bit(input string test, input string what, input logic expected,
			input logic actual);
		if (actual !== expected) begin
			$display("[FAIL] %s %s: expected %b, actual %b", test, what, expected, actual);
			$display("Simulation failed");
			$fatal(1, "Bit mismatch");
		end
	endtask

	task automatic check_hold(input string test, input packer_pkg::vec_t exp_act,
			input packer_pkg::vec_t exp_wgt);
		check_state(test, packer_pkg::ST_HOLD, state);
		check_bit(test, "input_taken", 1'b1, input_taken);
		check_vec(test, "act", exp_act, out_ops.act);
		check_vec(test, "wgt", exp_wgt, out_ops.wgt);
	endtask

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// One transaction from capture to release
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	task automatic run_transaction(input string name, input packer_pkg::operand_pair_t ops,
			input int hold_cycles, input bit poke_ready);
		packer_pkg::vec_t exp_act;
		packer_pkg::vec_t exp_wgt;
		exp_act     = pack_model(ops.act);
		exp_wgt     = pack_model(ops.wgt);
		in_ops      = ops;
		input_ready = 1'b1;
		next_cycle(); // Capture edge.
		input_ready = 1'b0;
		check_state(name, packer_pkg::ST_SCAN, state);
		check_bit(name, "input_taken", 1'b1, input_taken);
		for (int n = 1; n <= packer_pkg::LANES; n++) begin
			if (poke_ready) begin
				input_ready = n[0];
				in_ops.act  = random_vec();
				in_ops.wgt  = random_vec();
			end
			next_cycle();
			if (n < packer_pkg::LANES) begin
				check_state(name, packer_pkg::ST_SCAN, state);
				check_bit(name, "input_taken", 1'b1, input_taken);
			end
		end
		check_hold(name, exp_act, exp_wgt);
		for (int h = 0; h < hold_cycles; h++) begin
			if (poke_ready) begin
				input_ready = 1'b1;
				in_ops.act  = random_vec();
				in_ops.wgt  = random_vec();
			end
			next_cycle();
			check_hold(name, exp_act, exp_wgt);
		end
		input_ready  = 1'b0;
		output_taken = 1'b1;
		next_cycle(); // Release edge.
		output_taken = 1'b0;
		check_state(name, packer_pkg::ST_IDLE, state);
		check_bit(name, "input_taken", 1'b0, input_taken);
		check_vec(name, "act", '0, out_ops.act);
		check_vec(name, "wgt", '0, out_ops.wgt);
	endtask

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Directed tests
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	task automatic test_reset();
		check_state("reset", packer_pkg::ST_IDLE, state);
		check_bit("reset", "input_taken", 1'b0, input_taken);
		check_vec("reset", "act", '0, out_ops.act);
		check_vec("reset", "wgt", '0, out_ops.wgt);
	endtask

	task automatic test_dense();
		packer_pkg::operand_pair_t ops;
		for (int i = 0; i < packer_pkg::LANES; i++) begin
			ops.act[i] = packer_pkg::elem_t'(4096 + i * 291);
			ops.wgt[i] = packer_pkg::elem_t'(-(2048 + i)); // All negative.
		end
		run_transaction("dense", ops, 2, 1'b0);
	endtask

	task automatic test_sparse();
		packer_pkg::operand_pair_t ops;
		for (int i = 0; i < packer_pkg::LANES; i++) begin
			if (i == 0 || i == 3 || i == 4 || i == 9) begin
				ops.act[i] = '0;
			end else begin
				ops.act[i] = packer_pkg::elem_t'((i[0] ? -1 : 1) * (i * 4096 + 2048));
			end
			ops.wgt[i] = (i % 3 == 1) ? '0 : packer_pkg::elem_t'(i * 300 - 2000);
		end
		run_transaction("sparse", ops, 1, 1'b0);
	endtask

	task automatic test_zero_edge();
		packer_pkg::operand_pair_t ops;
		ops.act     = '0;
		ops.wgt     = '0;
		ops.wgt[15] = packer_pkg::elem_t'(-3072); // Only the top lane set.
		run_transaction("zero_edge", ops, 1, 1'b0);
	endtask

	task automatic test_back_pressure();
		packer_pkg::operand_pair_t ops;
		ops.act = random_vec();
		ops.wgt = random_vec();
		run_transaction("back_pressure", ops, 10, 1'b1);
		ops.act = random_vec();
		ops.wgt = random_vec();
		run_transaction("after_back_pressure", ops, 1, 1'b0);
	endtask

	task automatic test_random();
		packer_pkg::operand_pair_t ops;
		for (int t = 0; t < 5; t++) begin
			ops.act = random_vec();
			ops.wgt = random_vec();
			run_transaction($sformatf("random_%0d", t), ops, t, 1'b0);
		end
	endtask

	initial begin
		void'($urandom(81));
		reset        = 1'b1;
		in_ops       = '0;
		input_ready  = 1'b0;
		output_taken = 1'b0;
		repeat (16) @(posedge clk);
		#1;
		reset = 1'b0;
		test_reset();
		test_dense();
		test_sparse();
		test_zero_edge();
		test_back_pressure();
		test_random();
		$display("Simulation completed successfully");
		$finish;
	end

endmodule

//--- zero_skip_packer.f
design/packer_pkg.sv
design/pack_ctrl.sv
design/lane_compactor.sv
design/zero_skip_packer.sv
verif/zero_skip_packer_props.sv
verif/tb_zero_skip_packer.sv

//--- Makefile
# Verilator build and run for the zero-skipping packer.

VERILATOR ?= verilator
TOP       ?= tb_zero_skip_packer
FILELIST  ?= zero_skip_packer.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
PASS_MSG  ?= Simulation completed successfully
VFLAGS    ?= --binary --timing --assert -j 0

SOURCES := $(shell grep -v '^+' $(FILELIST))
SIM_BIN := $(BUILD_DIR)/V$(TOP)

.PHONY: all build run clean

all: run

build: $(SIM_BIN)

# Rebuilt only when a source or the file list changes.
$(SIM_BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)

run: $(SIM_BIN)
	-./$(SIM_BIN) 2>&1 | tee $(LOG)
	@grep -q "$(PASS_MSG)" $(LOG) || { echo "Run did not pass, see $(LOG)"; exit 1; }

clean:
	rm -rf $(BUILD_DIR) $(LOG)
